// File: bench/rsa_serial_model.sv
`timescale 1ns/10ps
`default_nettype none

module rsa_serial_model (
    input  logic                           avm_clk,
    input  logic                           avm_rst,
    input  logic [rsa_pkg::avm_addr_w-1:0] avm_address,
    input  logic                           avm_read,
    input  logic                           avm_write,
    input  logic [31:0]                    avm_writedata,
    output logic [31:0]                    avm_readdata,
    output logic                           avm_waitrequest
);
    import rsa_pkg::*;

    logic [7:0]  rx_q[$];                       // bytes waiting for the master.
    logic [7:0]  tx_q[$];                       // bytes the master has sent.
    logic [31:0] lcg_state;
    logic        tx_stall;
    logic        started;
    int          tx_busy;
    int          wait_left;
    int          rx_reads;
    int          tx_writes;
    int          proto_errors;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic push_rx(input logic [7:0] b);
        rx_q.push_back(b);
    endtask

    task automatic pop_tx(output logic [7:0] b);
        b = tx_q.pop_front();
    endtask

    function automatic int rx_count();
        return rx_q.size();
    endfunction

    function automatic int tx_count();
        return tx_q.size();
    endfunction

    task automatic set_tx_stall(input logic on);
        tx_stall = on;
    endtask

    task automatic complete_access();
        logic [31:0] status;
        status            = 32'd0;
        status[rx_ok_bit] = (rx_q.size() != 0);
        status[tx_ok_bit] = (tx_busy == 0);
        avm_readdata     <= 32'd0;
        if (avm_read && avm_address == status_base) begin
            avm_readdata <= status;
        end else if (avm_read && avm_address == rx_base) begin
            rx_reads++;
            if (rx_q.size() == 0) begin
                proto_errors++;
                $display("%0t: rx read issued while no received byte was waiting", $time);
            end else begin
                avm_readdata <= {24'd0, rx_q.pop_front()};
            end
        end else if (avm_write && avm_address == tx_base) begin
            tx_writes++;
            if (tx_busy != 0) begin
                proto_errors++;
                $display("%0t: tx write issued while the transmitter was busy", $time);
            end
            if (avm_writedata[31:8] != 24'd0) begin
                proto_errors++;
                $display("FAIL %0t: tx write upper data bits %06h, expected 0",
                         $time, avm_writedata[31:8]);
            end
            tx_q.push_back(avm_writedata[7:0]);
            if (tx_stall) begin
                tx_busy = int'(next_rand() >> 29) + 1;  // shifting the byte out.
            end
        end else begin
            proto_errors++;
            $display("%0t: transfer to unmapped address %0d", $time, avm_address);
        end
    endtask

    initial begin
        lcg_state       = 32'h1dd54d0e;
        avm_readdata    = 32'd0;
        avm_waitrequest = 1'b1;
        tx_stall        = 1'b0;
        started         = 1'b0;
        tx_busy         = 0;
        wait_left       = 0;
        rx_reads        = 0;
        tx_writes       = 0;
        proto_errors    = 0;
    end

    // a transfer is committed on the falling edge that drops waitrequest.
    always @(negedge avm_clk) begin
        avm_waitrequest <= 1'b1;
        if (tx_busy != 0) begin
            tx_busy--;
        end
        if (avm_rst) begin
            started = 1'b0;
        end else if (avm_read || avm_write) begin
            if (!started) begin
                started   = 1'b1;
                wait_left = int'(next_rand() >> 30);  // 0 to 3 stall cycles.
            end
            if (wait_left != 0) begin
                wait_left--;
            end else begin
                started          = 1'b0;
                avm_waitrequest <= 1'b0;
                complete_access();
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_rsa_wrapper.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rsa_wrapper;
    import rsa_pkg::*;

    typedef struct packed {
        rsa_job_t                job;
        logic [8*out_bytes-1:0]  want;         // low 248 bits of c^d mod n.
        logic                    rx_gaps;
        logic                    tx_stall;
    } test_entry_t;

    localparam int n_entries = 5;
    localparam int wd_cycles = n_entries * 70000 + 1000;

    logic                  avm_clk;
    logic                  avm_rst;
    logic [avm_addr_w-1:0] avm_address;
    logic                  avm_read;
    logic                  avm_write;
    logic [31:0]           avm_writedata;
    logic [31:0]           avm_readdata;
    logic                  avm_waitrequest;
    test_entry_t           entry_tab [n_entries];
    logic [31:0]           lcg_state;
    int                    data_errors;
    int                    frame_errors;
    int                    cur_entry;

    rsa_wrapper rsa_wrapper_i (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_readdata    (avm_readdata),
        .avm_waitrequest (avm_waitrequest)
    );

    rsa_serial_model port_i (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_readdata    (avm_readdata),
        .avm_waitrequest (avm_waitrequest)
    );

    initial avm_clk = 1'b0;
    always #2 avm_clk = ~avm_clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [rsa_bits-1:0] random_wide();
        logic [rsa_bits-1:0] w;
        for (int k = 0; k < rsa_bits / 32; k++) begin
            w[32*k +: 32] = next_rand();
        end
        return w;
    endfunction

    // square and multiply on double width values.
    function automatic logic [rsa_bits-1:0] mod_exp(input logic [rsa_bits-1:0] c,
                                                    input logic [rsa_bits-1:0] d,
                                                    input logic [rsa_bits-1:0] n);
        logic [2*rsa_bits-1:0] r;
        logic [2*rsa_bits-1:0] base;
        logic [2*rsa_bits-1:0] nn;
        nn   = {{rsa_bits{1'b0}}, n};
        r    = 1;
        base = {{rsa_bits{1'b0}}, c} % nn;
        for (int i = 0; i < rsa_bits; i++) begin
            if (d[i]) begin
                r = (r * base) % nn;
            end
            base = (base * base) % nn;
        end
        return r[rsa_bits-1:0];
    endfunction

    task automatic build_table();
        test_entry_t         e;
        rsa_job_t            j;
        logic [rsa_bits-1:0] full;
        for (int i = 0; i < n_entries; i++) begin
            if (i == 0) begin
                j.n = rsa_bits'(3233);
                j.d = rsa_bits'(2753);
                j.a = rsa_bits'(2790);
            end else begin
                j.n = random_wide() | {1'b1, {(rsa_bits-2){1'b0}}, 1'b1};  // full width, odd.
                j.d = (i == 2) ? rsa_bits'(1) : random_wide();
                j.a = (i == 3) ? '0 : random_wide() % j.n;
            end
            full       = mod_exp(j.a, j.d, j.n);
            e.job      = j;
            e.want     = full[8*out_bytes-1:0];
            e.rx_gaps  = (i == 2 || i == 4);
            e.tx_stall = (i == 3 || i == 4);
            entry_tab[i] = e;
        end
    endtask

    task automatic check_idle_bus(input string when_s);
        if (avm_read !== 1'b0 || avm_write !== 1'b0 || avm_address !== status_base) begin
            frame_errors++;
            $display("FAIL %0t: bus not idle %s, read %b write %b address %0d",
                     $time, when_s, avm_read, avm_write, avm_address);
        end
    endtask

    // n, d then a, each most significant byte first.
    task automatic load_job(input test_entry_t e);
        logic [3*rsa_bits-1:0] job_bits;
        job_bits = e.job;
        port_i.set_tx_stall(e.tx_stall);
        for (int k = 3 * rsa_bytes - 1; k >= 0; k--) begin
            if (e.rx_gaps) begin
                repeat (int'(next_rand() >> 29)) @(posedge avm_clk);
            end
            port_i.push_rx(job_bits[8*k +: 8]);
        end
    endtask

    task automatic collect_result(input int idx, input test_entry_t e);
        logic [7:0] got;
        logic [7:0] want;
        while (port_i.tx_count() < out_bytes) begin
            @(posedge avm_clk);
        end
        for (int k = 0; k < out_bytes; k++) begin
            port_i.pop_tx(got);
            want = e.want[8*(out_bytes-1-k) +: 8];
            if (got !== want) begin
                data_errors++;
                $display("FAIL %0t: entry %0d byte %0d got %02h expected %02h",
                         $time, idx, k, got, want);
            end
        end
    endtask

    task automatic check_framing(input int jobs);
        if (port_i.rx_reads != jobs * 3 * rsa_bytes || port_i.rx_count() != 0) begin
            frame_errors++;
            $display("FAIL %0t: %0d rx reads and %0d bytes left after %0d jobs",
                     $time, port_i.rx_reads, port_i.rx_count(), jobs);
        end
        if (port_i.tx_writes != jobs * out_bytes || port_i.tx_count() != 0) begin
            frame_errors++;
            $display("FAIL %0t: %0d tx writes after %0d jobs, expected %0d",
                     $time, port_i.tx_writes, jobs, jobs * out_bytes);
        end
    endtask

    initial begin
        avm_rst      = 1'b1;
        lcg_state    = 32'h1dd54d0e;
        data_errors  = 0;
        frame_errors = 0;
        cur_entry    = 0;
        build_table();
        repeat (10) begin
            @(negedge avm_clk);
            check_idle_bus("during reset");
        end
        avm_rst = 1'b0;
        #1;
        check_idle_bus("after reset");
        for (int i = 0; i < n_entries; i++) begin
            cur_entry = i;
            @(posedge avm_clk);
            load_job(entry_tab[i]);
            collect_result(i, entry_tab[i]);
            check_framing(i + 1);
        end
        repeat (100) @(posedge avm_clk);
        check_framing(n_entries);       // nothing extra after the last job.
        $display("errors: %0d data, %0d framing, %0d bus protocol",
                 data_errors, frame_errors, port_i.proto_errors);
        if (data_errors + frame_errors + port_i.proto_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        repeat (wd_cycles) @(posedge avm_clk);
        $display("timeout: entry %0d returned no complete result within %0d cycles",
                 cur_entry, wd_cycles);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
src/rsa_pkg.sv
src/rsa_pre_scale.sv
src/rsa_mont_mult.sv
src/rsa_core.sv
src/rsa_wrapper.sv
bench/rsa_serial_model.sv
bench/tb_rsa_wrapper.sv

// File: src/rsa_core.sv
`timescale 1ns/10ps
`default_nettype none

module rsa_core (
    input  logic                         avm_clk,
    input  logic                         avm_rst,
    input  logic                         start,
    input  rsa_pkg::rsa_job_t            job,
    output logic [rsa_pkg::rsa_bits-1:0] result,
    output logic                         finished
);
    import rsa_pkg::*;

    localparam int idx_w = $clog2(rsa_bits);

    core_state_e         state;
    logic [idx_w-1:0]    bit_idx;               // exponent bit, lsb first.
    logic [rsa_bits-1:0] m;                     // running product, plain domain.
    logic [rsa_bits-1:0] t;                     // a^(2^i) in Montgomery domain.
    logic                ps_start;
    logic                ps_done;
    logic [rsa_bits-1:0] ps_result;
    logic                mm_start;
    logic                prod_done;
    logic                sq_done;
    logic [rsa_bits-1:0] prod_result;
    logic [rsa_bits-1:0] sq_result;
    logic                step_done;

    assign ps_start  = start & (state == idle);
    assign step_done = prod_done & sq_done;
    assign result    = m;

    rsa_pre_scale pre_scale_i (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (ps_start),
        .a       (job.a),
        .n       (job.n),
        .result  (ps_result),
        .done    (ps_done)
    );

    // m * t keeps m in the plain domain.
    rsa_mont_mult prod_i (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (mm_start),
        .a       (m),
        .b       (t),
        .n       (job.n),
        .result  (prod_result),
        .done    (prod_done)
    );

    rsa_mont_mult sq_i (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (mm_start),
        .a       (t),
        .b       (t),
        .n       (job.n),
        .result  (sq_result),
        .done    (sq_done)
    );

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state    <= idle;
            bit_idx  <= '0;
            mm_start <= 1'b0;
            finished <= 1'b0;
        end else begin
            mm_start <= 1'b0;
            finished <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        state <= prescale;
                    end
                end
                prescale: begin
                    if (ps_done) begin
                        bit_idx  <= '0;
                        mm_start <= 1'b1;
                        state    <= ladder;
                    end
                end
                ladder: begin
                    if (step_done) begin
                        if (bit_idx == idx_w'(rsa_bits - 1)) begin
                            state <= finish;
                        end else begin
                            bit_idx  <= bit_idx + 1'b1;
                            mm_start <= 1'b1;   // next bit.
                        end
                    end
                end
                finish: begin
                    finished <= 1'b1;
                    state    <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        if (state == prescale && ps_done) begin
            t <= ps_result;
            m <= rsa_bits'(1);
        end else if (state == ladder && step_done) begin
            t <= sq_result;
            if (job.d[bit_idx]) begin
                m <= prod_result;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/rsa_mont_mult.sv
`timescale 1ns/10ps
`default_nettype none

module rsa_mont_mult (
    input  logic                         avm_clk,
    input  logic                         avm_rst,
    input  logic                         start,
    input  logic [rsa_pkg::rsa_bits-1:0] a,
    input  logic [rsa_pkg::rsa_bits-1:0] b,
    input  logic [rsa_pkg::rsa_bits-1:0] n,
    output logic [rsa_pkg::rsa_bits-1:0] result,
    output logic                         done
);
    import rsa_pkg::*;

    localparam int cnt_w = $clog2(rsa_bits);

    logic                busy;
    logic [cnt_w-1:0]    cnt;
    logic [rsa_bits-1:0] a_sh;                  // multiplier bits, lsb first.
    logic [rsa_bits-1:0] b_r;
    logic [rsa_bits:0]   acc;                   // stays below 2n.
    logic [rsa_bits+1:0] sum_b;
    logic [rsa_bits+1:0] sum_n;
    logic [rsa_bits:0]   acc_sub;

    always_comb begin
        sum_b = {1'b0, acc} + (a_sh[0] ? {2'b00, b_r} : '0);
        sum_n = sum_b[0] ? sum_b + {2'b00, n} : sum_b;  // make it even.
    end

    // final conditional subtraction, borrow means acc already below n.
    assign acc_sub = acc - {1'b0, n};
    assign result  = acc_sub[rsa_bits] ? acc[rsa_bits-1:0] : acc_sub[rsa_bits-1:0];

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == cnt_w'(rsa_bits - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (start) begin
            a_sh <= a;
            b_r  <= b;
            acc  <= '0;
        end else if (busy) begin
            a_sh <= a_sh >> 1;
            acc  <= sum_n[rsa_bits+1:1];        // halve.
        end
    end

endmodule

`default_nettype wire

// File: src/rsa_pkg.sv
`default_nettype none

package rsa_pkg;

    localparam int rsa_bits  = 256;            // operand width.
    localparam int rsa_bytes = rsa_bits / 8;
    localparam int out_bytes = rsa_bytes - 1;  // plaintext block is 248 bits.

    localparam int avm_addr_w = 5;

    // serial port register map, byte offsets.
    localparam logic [avm_addr_w-1:0] rx_base     = avm_addr_w'(0);
    localparam logic [avm_addr_w-1:0] tx_base     = avm_addr_w'(4);
    localparam logic [avm_addr_w-1:0] status_base = avm_addr_w'(8);

    localparam int rx_ok_bit = 7;              // received byte waiting.
    localparam int tx_ok_bit = 6;              // transmitter can take a byte.

    typedef struct packed {
        logic [rsa_bits-1:0] n;                // modulus.
        logic [rsa_bits-1:0] d;                // private exponent.
        logic [rsa_bits-1:0] a;                // ciphertext.
    } rsa_job_t;

    typedef enum logic [2:0] {
        poll_rx,
        read_rx,
        wait_core,
        poll_tx,
        write_tx
    } wrap_state_e;

    typedef enum logic [1:0] {
        idle,
        prescale,
        ladder,
        finish
    } core_state_e;

endpackage

`default_nettype wire

// File: src/rsa_pre_scale.sv
`timescale 1ns/10ps
`default_nettype none

module rsa_pre_scale (
    input  logic                         avm_clk,
    input  logic                         avm_rst,
    input  logic                         start,
    input  logic [rsa_pkg::rsa_bits-1:0] a,
    input  logic [rsa_pkg::rsa_bits-1:0] n,
    output logic [rsa_pkg::rsa_bits-1:0] result,
    output logic                         done
);
    import rsa_pkg::*;

    localparam int cnt_w = $clog2(rsa_bits + 1);

    logic                busy;
    logic [cnt_w-1:0]    cnt;
    logic [rsa_bits-1:0] val;
    logic [rsa_bits:0]   cand;
    logic [rsa_bits:0]   diff;

    // round 0 only folds a below n, the other 256 rounds double.
    always_comb begin
        cand = (cnt == '0) ? {1'b0, val} : {val, 1'b0};
        diff = cand - {1'b0, n};
    end

    assign result = val;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == cnt_w'(rsa_bits)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (start) begin
            val <= a;                           // expected below 2n.
        end else if (busy) begin
            val <= diff[rsa_bits] ? cand[rsa_bits-1:0] : diff[rsa_bits-1:0];
        end
    end

endmodule

`default_nettype wire

// File: src/rsa_wrapper.sv
`timescale 1ns/10ps
`default_nettype none

module rsa_wrapper (
    input  logic                           avm_clk,
    input  logic                           avm_rst,
    output logic [rsa_pkg::avm_addr_w-1:0] avm_address,
    output logic                           avm_read,
    output logic                           avm_write,
    output logic [31:0]                    avm_writedata,
    input  logic [31:0]                    avm_readdata,
    input  logic                           avm_waitrequest
);
    import rsa_pkg::*;

    localparam int job_bytes = 3 * rsa_bytes;
    localparam int cnt_w     = $clog2(job_bytes);
    localparam int out_bits  = 8 * out_bytes;

    wrap_state_e         state;
    logic [cnt_w-1:0]    byte_cnt;
    rsa_job_t            job;                   // n, d, a in arrival order.
    logic [out_bits-1:0] out_sh;                // result bytes, msb first.
    logic                core_start;
    logic                core_finished;
    logic [rsa_bits-1:0] core_result;
    logic                xfer_done;

    // the one transfer in flight completes here.
    assign xfer_done     = (avm_read | avm_write) & ~avm_waitrequest;
    assign avm_writedata = {24'd0, out_sh[out_bits-1 -: 8]};

    rsa_core core_i (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .start    (core_start),
        .job      (job),
        .result   (core_result),
        .finished (core_finished)
    );

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state       <= poll_rx;
            byte_cnt    <= '0;
            avm_address <= status_base;
            avm_read    <= 1'b0;
            avm_write   <= 1'b0;
            core_start  <= 1'b0;
        end else begin
            core_start <= 1'b0;
            case (state)
                poll_rx: begin
                    if (!avm_read) begin
                        avm_read    <= 1'b1;
                        avm_address <= status_base;
                    end else if (xfer_done) begin
                        avm_read <= 1'b0;
                        if (avm_readdata[rx_ok_bit]) begin
                            state <= read_rx;
                        end
                    end
                end
                read_rx: begin
                    if (!avm_read) begin
                        avm_read    <= 1'b1;
                        avm_address <= rx_base;
                    end else if (xfer_done) begin
                        avm_read    <= 1'b0;
                        avm_address <= status_base;
                        if (byte_cnt == cnt_w'(job_bytes - 1)) begin
                            byte_cnt   <= '0;
                            core_start <= 1'b1;
                            state      <= wait_core;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                            state    <= poll_rx;
                        end
                    end
                end
                wait_core: begin
                    if (core_finished) begin
                        state <= poll_tx;
                    end
                end
                poll_tx: begin
                    if (!avm_read) begin
                        avm_read    <= 1'b1;
                        avm_address <= status_base;
                    end else if (xfer_done) begin
                        avm_read <= 1'b0;
                        if (avm_readdata[tx_ok_bit]) begin
                            state <= write_tx;
                        end
                    end
                end
                write_tx: begin
                    if (!avm_write) begin
                        avm_write   <= 1'b1;
                        avm_address <= tx_base;
                    end else if (xfer_done) begin
                        avm_write   <= 1'b0;
                        avm_address <= status_base;
                        if (byte_cnt == cnt_w'(out_bytes - 1)) begin
                            byte_cnt <= '0;
                            state    <= poll_rx;   // ready for the next job.
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                            state    <= poll_tx;
                        end
                    end
                end
                default: state <= poll_rx;
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        if (state == read_rx && xfer_done) begin
            job <= rsa_job_t'({job[3*rsa_bits-9:0], avm_readdata[7:0]});
        end
        if (state == wait_core && core_finished) begin
            out_sh <= core_result[out_bits-1:0];  // top byte of the 256 is dropped.
        end else if (state == write_tx && xfer_done) begin
            out_sh <= out_sh << 8;
        end
    end

endmodule

`default_nettype wire
